// ==== src/backend_pkg.sv ====
package backend_pkg;

  localparam int XLEN      = 32;
  localparam int AREG_W    = 3;
  localparam int ROB_DEPTH = 8;
  localparam int TAG_W     = 3;
  localparam int IMM_W     = 7;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4,
    OP_MUL  = 3'd5
  } opcode_e;

  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  typedef struct packed {
    opcode_e             opcode;
    logic [AREG_W-1:0]   rd;
    logic [AREG_W-1:0]   rs1;
    logic [AREG_W-1:0]   rs2;
    logic [3:0]          pad;
  } inst_reg_t;

  typedef struct packed {
    opcode_e             opcode;
    logic [AREG_W-1:0]   rd;
    logic [AREG_W-1:0]   rs1;
    logic [IMM_W-1:0]    imm;
  } inst_imm_t;

  // same 16-bit word, imm view only for ADDI
  typedef union packed {
    inst_reg_t r;
    inst_imm_t i;
  } inst_u;

  typedef struct packed {
    logic              ready;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   value;
  } operand_t;

  typedef struct packed {
    opcode_e           opcode;
    logic [TAG_W-1:0]  tag;
    operand_t          src1;
    operand_t          src2;
  } uop_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [XLEN-1:0]   value;
  } cdb_t;

  typedef struct packed {
    logic [AREG_W-1:0] rd;
    logic [XLEN-1:0]   value;
  } retire_t;

  function automatic unit_e unit_of(opcode_e op);
    return (op == OP_MUL) ? UNIT_MUL : UNIT_ALU;
  endfunction

  // capture a broadcast result into a waiting operand
  function automatic operand_t snoop(operand_t op, cdb_t cdb);
    operand_t res;
    res = op;
    if (!op.ready && cdb.valid && cdb.tag == op.tag) begin
      res.ready = 1'b1;
      res.value = cdb.value;
    end
    return res;
  endfunction

endpackage

// ==== src/rename_table.sv ====
`timescale 1ns/10ps

module rename_table import backend_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [AREG_W-1:0] rs1_i,
  input  logic [AREG_W-1:0] rs2_i,
  output operand_t          src1_o,
  output operand_t          src2_o,
  input  logic              alloc_i,
  input  logic [AREG_W-1:0] alloc_rd_i,
  input  logic [TAG_W-1:0]  alloc_tag_i,
  input  logic              retire_valid_i,
  input  retire_t           retire_i,
  input  logic [TAG_W-1:0]  retire_tag_i
);

  localparam int NREG = 1 << AREG_W;

  logic [XLEN-1:0]  val_q  [NREG];
  logic [TAG_W-1:0] tag_q  [NREG];
  logic [NREG-1:0]  pend_q;          // register waits on a rob entry

  logic retire_owner;
  assign retire_owner = pend_q[retire_i.rd] && tag_q[retire_i.rd] == retire_tag_i;

  assign src1_o = '{ready: !pend_q[rs1_i], tag: tag_q[rs1_i], value: val_q[rs1_i]};
  assign src2_o = '{ready: !pend_q[rs2_i], tag: tag_q[rs2_i], value: val_q[rs2_i]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
      for (int i = 0; i < NREG; i++) begin
        val_q[i] <= '0;
        tag_q[i] <= '0;
      end
    end else begin
      // older writer retiring, ignored once a younger one owns rd
      if (retire_valid_i && retire_owner) begin
        val_q[retire_i.rd]  <= retire_i.value;
        pend_q[retire_i.rd] <= 1'b0;
      end
      if (alloc_i) begin
        pend_q[alloc_rd_i] <= 1'b1;   // wins over a same-cycle retire
        tag_q[alloc_rd_i]  <= alloc_tag_i;
      end
    end
  end

endmodule

// ==== src/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer import backend_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alloc_i,
  input  logic [AREG_W-1:0] alloc_rd_i,
  output logic [TAG_W-1:0]  alloc_tag_o,
  input  logic [TAG_W-1:0]  query1_tag_i,
  input  logic [TAG_W-1:0]  query2_tag_i,
  output operand_t          fwd1_o,
  output operand_t          fwd2_o,
  input  cdb_t              cdb_i,
  output logic              retire_valid_o,
  output retire_t           retire_o,
  output logic [TAG_W-1:0]  retire_tag_o
);

  logic [TAG_W-1:0]     head_q;
  logic [TAG_W-1:0]     tail_q;
  logic [ROB_DEPTH-1:0] valid_q;
  logic [ROB_DEPTH-1:0] done_q;
  logic [AREG_W-1:0]    rd_q  [ROB_DEPTH];
  logic [XLEN-1:0]      val_q [ROB_DEPTH];

  assign alloc_tag_o = tail_q;

  // finished entries feed dispatch directly
  assign fwd1_o = '{
    ready: valid_q[query1_tag_i] && done_q[query1_tag_i],
    tag:   query1_tag_i,
    value: val_q[query1_tag_i]
  };
  assign fwd2_o = '{
    ready: valid_q[query2_tag_i] && done_q[query2_tag_i],
    tag:   query2_tag_i,
    value: val_q[query2_tag_i]
  };

  assign retire_valid_o = valid_q[head_q] && done_q[head_q];
  assign retire_o       = '{rd: rd_q[head_q], value: val_q[head_q]};
  assign retire_tag_o   = head_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      if (retire_valid_o) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (cdb_i.valid) begin
        done_q[cdb_i.tag] <= 1'b1;
      end
      // credits keep tail off a live head
      if (alloc_i) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_i.valid) begin
      val_q[cdb_i.tag] <= cdb_i.value;
    end
  end

endmodule

// ==== src/issue_queue.sv ====
`timescale 1ns/10ps

module issue_queue import backend_pkg::*; #(
  parameter unit_e UNIT = UNIT_ALU
) (
  input  logic clk,
  input  logic rst_n,
  input  logic write_i,
  input  uop_t write_uop_i,
  input  cdb_t cdb_i,
  output logic issue_valid_o,
  output uop_t issue_uop_o,
  input  logic accept_i
);

  // collapsing queue, slot 0 is the oldest
  uop_t [ROB_DEPTH-1:0] slot_q;
  uop_t [ROB_DEPTH-1:0] slot_d;
  logic [TAG_W:0]       cnt_q;
  logic [TAG_W:0]       cnt_d;
  logic [TAG_W-1:0]     sel;
  logic                 found;
  logic                 take;
  logic                 fire;

  assign take = write_i && unit_of(write_uop_i.opcode) == UNIT;

  // oldest entry with both operands in hand
  always_comb begin
    sel   = '0;
    found = 1'b0;
    for (int i = 0; i < ROB_DEPTH; i++) begin
      if (!found && i < cnt_q && slot_q[i].src1.ready && slot_q[i].src2.ready) begin
        found = 1'b1;
        sel   = TAG_W'(i);
      end
    end
  end

  assign issue_valid_o = found;
  assign issue_uop_o   = slot_q[sel];
  assign fire          = found && accept_i;

  always_comb begin
    slot_d = slot_q;
    cdb_ok: for (int i = 0; i < ROB_DEPTH; i++) begin
      slot_d[i].src1 = snoop(slot_q[i].src1, cdb_i);
      slot_d[i].src2 = snoop(slot_q[i].src2, cdb_i);
    end
    cnt_d = cnt_q;
    if (fire) begin
      for (int i = 0; i < ROB_DEPTH - 1; i++) begin
        if (i >= sel) begin
          slot_d[i] = slot_d[i+1];
        end
      end
      cnt_d = cnt_d - 1'b1;
    end
    if (take) begin
      slot_d[cnt_d[TAG_W-1:0]] = write_uop_i;   // dispatch already saw this cdb
      cnt_d = cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_d;
  end

endmodule

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit import backend_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  uop_t uop_i,
  output logic accept_o,
  input  logic grant_i,
  output cdb_t req_o
);

  logic             res_valid_q;
  logic [TAG_W-1:0] res_tag_q;
  logic [XLEN-1:0]  res_val_q;
  logic [XLEN-1:0]  result;

  always_comb begin
    case (uop_i.opcode)
      OP_ADD, OP_ADDI: result = uop_i.src1.value + uop_i.src2.value; // imm already in src2
      OP_SUB:          result = uop_i.src1.value - uop_i.src2.value;
      OP_AND:          result = uop_i.src1.value & uop_i.src2.value;
      OP_XOR:          result = uop_i.src1.value ^ uop_i.src2.value;
      default:         result = '0;
    endcase
  end

  // free slot, or the held result leaves this cycle
  assign accept_o = !res_valid_q || grant_i;
  assign req_o    = '{valid: res_valid_q, tag: res_tag_q, value: res_val_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else if (accept_o) begin
      res_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && accept_o) begin
      res_tag_q <= uop_i.tag;
      res_val_q <= result;
    end
  end

endmodule

// ==== src/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit import backend_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  uop_t uop_i,
  output logic accept_o,
  input  logic grant_i,
  output cdb_t req_o
);

  logic [2:0]         vld_q;          // one bit per stage
  logic [TAG_W-1:0]   tag_q [3];
  logic [XLEN-1:0]    a_q;
  logic [XLEN-1:0]    b_q;
  logic [XLEN-1:0]    lo_q;           // a * b[15:0]
  logic [XLEN/2-1:0]  hi_q;           // low half of a * b[31:16]
  logic [XLEN-1:0]    res_q;

  // whole pipe freezes behind an ungranted result
  assign accept_o = !(vld_q[2] && !grant_i);
  assign req_o    = '{valid: vld_q[2], tag: tag_q[2], value: res_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (accept_o) begin
      vld_q <= {vld_q[1:0], valid_i};
    end
  end

  always_ff @(posedge clk) begin
    if (accept_o) begin
      tag_q[0] <= uop_i.tag;
      tag_q[1] <= tag_q[0];
      tag_q[2] <= tag_q[1];
      a_q      <= uop_i.src1.value;
      b_q      <= uop_i.src2.value;
      lo_q     <= a_q * {{(XLEN/2){1'b0}}, b_q[XLEN/2-1:0]};
      hi_q     <= a_q[XLEN/2-1:0] * b_q[XLEN-1:XLEN/2];
      res_q    <= lo_q + {hi_q, {(XLEN/2){1'b0}}};
    end
  end

endmodule

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/10ps

module cdb_arbiter import backend_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  cdb_t alu_req_i,
  input  cdb_t mul_req_i,
  output logic alu_grant_o,
  output logic mul_grant_o,
  output cdb_t cdb_o
);

  logic mul_prio_q;   // set when the multiplier lost the last tie

  assign alu_grant_o = alu_req_i.valid && (!mul_req_i.valid || !mul_prio_q);
  assign mul_grant_o = mul_req_i.valid && !alu_grant_o;

  // idle bus carries the mul request with valid low
  assign cdb_o = alu_grant_o ? alu_req_i : mul_req_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mul_prio_q <= 1'b0;
    end else if (alu_req_i.valid && mul_req_i.valid) begin
      mul_prio_q <= alu_grant_o;
    end
  end

endmodule

// ==== src/ooo_backend.sv ====
`timescale 1ns/10ps

module ooo_backend import backend_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    inst_valid_i,
  input  inst_u   inst_i,
  output logic    commit_valid_o,
  output retire_t commit_o,
  output logic    credit_o
);

  operand_t         rt_src1, rt_src2;
  operand_t         fwd1, fwd2;
  operand_t         imm_op;
  logic [TAG_W-1:0] alloc_tag;
  logic             retire_valid;
  retire_t          retire;
  logic [TAG_W-1:0] retire_tag;
  cdb_t             cdb, alu_req, mul_req;
  logic             alu_grant, mul_grant;
  logic             alu_iss_valid, mul_iss_valid, alu_accept, mul_accept;
  uop_t             alu_iss_uop, mul_iss_uop;
  uop_t             disp_uop;

  // table value, then finished rob entry, then the live cdb
  function automatic operand_t pick(operand_t rt, operand_t fwd, cdb_t bus);
    if (rt.ready) begin
      return rt;
    end
    if (fwd.ready) begin
      return fwd;
    end
    return snoop(rt, bus);
  endfunction

  assign imm_op = '{
    ready: 1'b1,
    tag:   '0,
    value: {{(XLEN-IMM_W){inst_i.i.imm[IMM_W-1]}}, inst_i.i.imm}
  };

  always_comb begin
    disp_uop.opcode = inst_i.r.opcode;
    disp_uop.tag    = alloc_tag;
    disp_uop.src1   = pick(rt_src1, fwd1, cdb);
    disp_uop.src2   = (inst_i.r.opcode == OP_ADDI) ? imm_op : pick(rt_src2, fwd2, cdb);
  end

  rename_table u_rename_table (
    .clk, .rst_n,
    .rs1_i(inst_i.r.rs1), .rs2_i(inst_i.r.rs2),
    .src1_o(rt_src1), .src2_o(rt_src2),
    .alloc_i(inst_valid_i), .alloc_rd_i(inst_i.r.rd), .alloc_tag_i(alloc_tag),
    .retire_valid_i(retire_valid), .retire_i(retire), .retire_tag_i(retire_tag)
  );

  reorder_buffer u_rob (
    .clk, .rst_n,
    .alloc_i(inst_valid_i), .alloc_rd_i(inst_i.r.rd), .alloc_tag_o(alloc_tag),
    .query1_tag_i(rt_src1.tag), .query2_tag_i(rt_src2.tag),
    .fwd1_o(fwd1), .fwd2_o(fwd2),
    .cdb_i(cdb),
    .retire_valid_o(retire_valid), .retire_o(retire), .retire_tag_o(retire_tag)
  );

  // each queue keeps only its own class
  issue_queue #(.UNIT(UNIT_ALU)) u_alu_iq (
    .clk, .rst_n,
    .write_i(inst_valid_i), .write_uop_i(disp_uop), .cdb_i(cdb),
    .issue_valid_o(alu_iss_valid), .issue_uop_o(alu_iss_uop), .accept_i(alu_accept)
  );

  issue_queue #(.UNIT(UNIT_MUL)) u_mul_iq (
    .clk, .rst_n,
    .write_i(inst_valid_i), .write_uop_i(disp_uop), .cdb_i(cdb),
    .issue_valid_o(mul_iss_valid), .issue_uop_o(mul_iss_uop), .accept_i(mul_accept)
  );

  alu_unit u_alu (
    .clk, .rst_n, .valid_i(alu_iss_valid), .uop_i(alu_iss_uop),
    .accept_o(alu_accept), .grant_i(alu_grant), .req_o(alu_req)
  );

  mul_unit u_mul (
    .clk, .rst_n, .valid_i(mul_iss_valid), .uop_i(mul_iss_uop),
    .accept_o(mul_accept), .grant_i(mul_grant), .req_o(mul_req)
  );

  cdb_arbiter u_cdb_arb (
    .clk, .rst_n, .alu_req_i(alu_req), .mul_req_i(mul_req),
    .alu_grant_o(alu_grant), .mul_grant_o(mul_grant), .cdb_o(cdb)
  );

  assign commit_valid_o = retire_valid;
  assign commit_o       = retire;
  assign credit_o       = retire_valid;   // one credit back per retirement

endmodule

// ==== dv/backend_tb.sv ====
`timescale 1ns/10ps

module backend_tb import backend_pkg::*; ();

  localparam int CREDIT_TIMEOUT = 200;
  localparam int RETIRE_TIMEOUT = 500;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    inst_valid_i;
  inst_u   inst_i;
  logic    commit_valid_o;
  retire_t commit_o;
  logic    credit_o;

  logic [15:0]       inst_q    [$];
  logic [AREG_W-1:0] exp_rd_q  [$];
  logic [XLEN-1:0]   exp_val_q [$];

  int          errors     = 0;
  int          sent       = 0;
  int          dispatched = 0;   // seen by the DUT at an edge
  int          returned   = 0;
  int          retired    = 0;
  logic        reset_seen = 1'b0;
  logic        timed_out  = 1'b0;
  logic [15:0] lfsr       = 16'd32630;

  always #10 clk = ~clk;

  ooo_backend u_ooo_backend (
    .clk, .rst_n, .inst_valid_i, .inst_i, .commit_valid_o, .commit_o, .credit_o
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          rc;
    string       line;
    logic [15:0] word;
    logic [31:0] rd;
    logic [31:0] val;
    fd = $fopen("dv/backend_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/backend_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%h %h %h", word, rd, val);
        if (rc == 3) begin
          inst_q.push_back(word);
          exp_rd_q.push_back(rd[AREG_W-1:0]);
          exp_val_q.push_back(val);
        end else begin
          $display("malformed line in case file: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // random idle gap, then wait for a credit and send one instruction
  task automatic send_inst(input logic [15:0] word);
    logic [1:0] gap;
    int         wait_cnt;
    lfsr = lfsr_next(lfsr);
    gap[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    gap[1] = lfsr[0];
    repeat (gap) begin
      @(posedge clk);
      inst_valid_i <= 1'b0;
    end
    @(posedge clk);
    wait_cnt = 0;
    while (ROB_DEPTH - sent + returned <= 0 && wait_cnt < CREDIT_TIMEOUT) begin
      inst_valid_i <= 1'b0;
      @(posedge clk);
      wait_cnt++;
    end
    if (ROB_DEPTH - sent + returned <= 0) begin
      $display("no credit came back within %0d cycles after %0d sends", CREDIT_TIMEOUT, sent);
      timed_out = 1'b1;
      inst_valid_i <= 1'b0;
    end else begin
      inst_valid_i <= 1'b1;
      inst_i       <= word;
      sent++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_seen <= 1'b1;   // outputs defined from the next edge on
    end
    if (reset_seen) begin
      if (dispatched == 0) begin
        check_value("commit_valid_o", commit_valid_o, 0);
        check_value("credit_o", credit_o, 0);
      end
      if (inst_valid_i) begin
        dispatched <= dispatched + 1;
      end
      if (credit_o) begin
        if (returned >= dispatched) begin
          $display("credit returned with no instruction in flight at %0t", $time);
          errors++;
        end
        returned <= returned + 1;
      end
      if (commit_valid_o) begin
        if (retired >= exp_rd_q.size()) begin
          $display("retirement %0d has no matching case line", retired);
          errors++;
        end else begin
          check_value("commit_o.rd", commit_o.rd, exp_rd_q[retired]);
          check_value("commit_o.value", commit_o.value, exp_val_q[retired]);
        end
        retired <= retired + 1;
      end
    end
  end

  initial begin
    int wait_cnt;
    rst_n        = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    load_cases();
    if (inst_q.size() == 0) begin
      $display("case file holds no instructions");
      errors++;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < inst_q.size() && !timed_out; i++) begin
      send_inst(inst_q[i]);
    end
    @(posedge clk);
    inst_valid_i <= 1'b0;
    wait_cnt = 0;
    while (retired < inst_q.size() && wait_cnt < RETIRE_TIMEOUT && !timed_out) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (retired < inst_q.size() && !timed_out) begin
      $display("timed out with %0d of %0d instructions retired", retired, inst_q.size());
      timed_out = 1'b1;
    end
    repeat (8) @(posedge clk);   // catch stray retirements
    check_value("credit_o pulses", returned, sent);
    check_value("retirements", retired, inst_q.size());
    $display("errors: %0d, sent: %0d, retired: %0d, timeouts: %0d",
             errors, sent, retired, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== dv/backend_cases.txt ====
# inst_hex rd value_hex
# instruction word in inst_u layout, then the rd and value expected at its retirement
8405 1 00000005
887D 2 FFFFFFFD
8C3F 3 0000003F
9040 4 FFFFFFC0
14A0 5 00000002
3990 6 0000003A
5E30 7 00000000
7D40 7 0000003D
03F0 0 0000007A
A730 1 00000E46
8A81 2 00000003
6EE0 3 00000038
10A0 4 00000E49
B640 5 00CC10D1
B940 6 00002ADB
3C30 7 00000042
807F 0 00000079
A6E0 1 2954ACCB
48F0 2 00000042
8D0A 3 0000004C
8DF6 3 00000042
71A0 4 00000000
B400 5 00003931
BB80 6 00001F32
BD20 7 00001104
02E0 0 00005863
2670 1 FFFFEEFC
A890 2 01218810
8C94 3 FFFFEF10
7190 4 000001EC
1540 5 012189FC
BA40 6 0003B190
3F00 7 0003592D
03D0 0 0124E329

// ==== flist.f ====
src/backend_pkg.sv
src/rename_table.sv
src/reorder_buffer.sv
src/issue_queue.sv
src/alu_unit.sv
src/mul_unit.sv
src/cdb_arbiter.sv
src/ooo_backend.sv
dv/backend_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module backend_tb \
  -f flist.f -o backend_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build exited with status $status"
  exit 1
fi

./obj_dir/backend_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
